// File: sim.f
+incdir+sim
src/mb_pkg.sv
src/mb_cam.sv
src/mb_alloc.sv
src/mb_retire.sv
src/mb_top.sv
sim/mb_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := mb_tb
FILELIST  := sim.f
VFLAGS    := --binary --timing
LINTFLAGS := --lint-only --timing -Wall
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST PASS

SOURCES := $(wildcard src/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/mb_tb_table.svh
//////////////////////////////////////////////////////////////////////
// directed miss and fill sequence with expected outcomes
//////////////////////////////////////////////////////////////////////

// columns: is_fill, pair, addr, id, flags {dup, full, conf}
// miss rows give the request address and the expected id and flags
// fill rows give the entry to fill and the expected retire address
// pair issues this fill and the next row's fill on consecutive cycles

localparam int TBL_LEN = 24;

localparam op_row_t OP_TBL [TBL_LEN] = '{
  // empty buffer, lowest free entry each time
  '{1'b0, 1'b0, 40'h10_0000_0100, 4'd0,  3'b000},
  '{1'b0, 1'b0, 40'h20_0000_0200, 4'd1,  3'b000},
  '{1'b0, 1'b0, 40'h30_0000_0300, 4'd2,  3'b000},
  // same line as entry 0, other byte offset
  '{1'b0, 1'b0, 40'h10_0000_0155, 4'd0,  3'b100},
  // new line, set index shared with entry 0
  '{1'b0, 1'b0, 40'h40_0000_0100, 4'd3,  3'b001},
  // free both entries of set 0x001, retire order follows fill order
  '{1'b1, 1'b1, 40'h40_0000_0100, 4'd3,  3'b000},
  '{1'b1, 1'b0, 40'h10_0000_0100, 4'd0,  3'b000},
  '{1'b0, 1'b0, 40'h40_0000_0100, 4'd0,  3'b000},
  // freed line is no longer a duplicate
  '{1'b0, 1'b0, 40'h10_0000_0100, 4'd3,  3'b001},
  // fill the remaining entries, distinct sets
  '{1'b0, 1'b0, 40'h50_0000_1000, 4'd4,  3'b000},
  '{1'b0, 1'b0, 40'h50_0000_1100, 4'd5,  3'b000},
  '{1'b0, 1'b0, 40'h50_0000_1200, 4'd6,  3'b000},
  '{1'b0, 1'b0, 40'h50_0000_1300, 4'd7,  3'b000},
  '{1'b0, 1'b0, 40'h50_0000_1400, 4'd8,  3'b000},
  '{1'b0, 1'b0, 40'h50_0000_1500, 4'd9,  3'b000},
  '{1'b0, 1'b0, 40'h50_0000_1600, 4'd10, 3'b000},
  '{1'b0, 1'b0, 40'h50_0000_1700, 4'd11, 3'b000},
  '{1'b0, 1'b0, 40'h50_0000_1800, 4'd12, 3'b000},
  '{1'b0, 1'b0, 40'h50_0000_1900, 4'd13, 3'b000},
  '{1'b0, 1'b0, 40'h50_0000_1A00, 4'd14, 3'b000},
  '{1'b0, 1'b0, 40'h50_0000_1B00, 4'd15, 3'b000},
  // all 16 valid
  '{1'b0, 1'b0, 40'h60_0000_0900, 4'd0,  3'b010},
  '{1'b1, 1'b0, 40'h50_0000_1300, 4'd7,  3'b000},
  '{1'b0, 1'b0, 40'h60_0000_0900, 4'd7,  3'b000}
};

// File: sim/mb_tb.sv
//////////////////////////////////////////////////////////////////////
// miss buffer testbench, directed table then random misses and
// fills checked against a reference model, watchdog
//////////////////////////////////////////////////////////////////////

module mb_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import mb_pkg::*;

  typedef struct packed {
    logic dup;
    logic full;
    logic conf;
  } miss_flags_t;

  typedef struct packed {
    logic        is_fill;
    logic        pair;
    mb_addr_t    addr;
    mb_id_t      id;
    miss_flags_t flags;
  } op_row_t;

  `include "mb_tb_table.svh"

  localparam int N_RAND      = 80;
  localparam int PULSE_LIMIT = 20;
  // 20 cycles of 4 ns per operation, plus reset and margin
  localparam int WATCHDOG_NS = (TBL_LEN + N_RAND) * 20 * 4 + 400;

  logic        rclk;
  logic        rst_l;
  logic        miss_vld;
  mb_addr_t    miss_addr;
  logic        miss_rdy;
  logic        miss_done;
  mb_id_t      miss_id;
  logic        miss_dup;
  logic        miss_full;
  logic        miss_conf;
  logic        fill_vld;
  mb_id_t      fill_id;
  logic        retire_vld;
  mb_addr_t    retire_addr;

  int          val_errs;
  int          pulse_errs;
  logic [31:0] rng;

  // reference model of the buffer
  mb_wl_t      ref_vld;
  mb_addr_t    ref_addr [MB_ENTRIES];

  mb_top i_dut (.*);

  initial rclk = 1'b0;
  always #2 rclk = ~rclk;

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic mb_id_t lowest_set(input mb_wl_t v);
    for (int j = 0; j < MB_ENTRIES; j++) begin
      if (v[j]) begin
        return mb_id_t'(j);
      end
    end
    return '0;
  endfunction

  // first valid entry at or after start, wrapping
  function automatic mb_id_t pick_valid(input mb_wl_t v, input mb_id_t start);
    mb_id_t id;
    id = start;
    for (int j = 0; j < MB_ENTRIES; j++) begin
      if (v[id]) begin
        return id;
      end
      id = id + mb_id_t'(1);
    end
    return start;
  endfunction

  task automatic check_miss(input mb_id_t got_id, input miss_flags_t got_f,
                            input mb_id_t exp_id, input miss_flags_t exp_f);
    if (got_id !== exp_id || got_f !== exp_f) begin
      val_errs++;
      $display("Fail %0t: miss id %0d dup/full/conf %b, expected id %0d %b",
               $time, got_id, got_f, exp_id, exp_f);
    end
  endtask

  task automatic check_addr(input mb_addr_t got, input mb_addr_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("Fail %0t: retire_addr %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic reset_dut();
    rst_l = 1'b0;
    repeat (2) @(negedge rclk);
    rst_l = 1'b1;
  endtask

  // request a miss, return the outcome carried by the miss_done pulse
  task automatic run_miss(input mb_addr_t addr, output mb_id_t id,
                          output miss_flags_t f, output logic seen);
    int n;
    seen = 1'b0;
    id   = '0;
    f    = '0;
    n    = 0;
    while (miss_rdy !== 1'b1 && n < PULSE_LIMIT) begin
      @(negedge rclk);
      n++;
    end
    miss_vld  = 1'b1;
    miss_addr = addr;
    @(negedge rclk);
    miss_vld  = 1'b0;
    // step past the pulse once it is seen
    for (n = 0; n < PULSE_LIMIT && !seen; n++) begin
      if (miss_done === 1'b1) begin
        seen = 1'b1;
        id   = miss_id;
        f    = '{miss_dup, miss_full, miss_conf};
      end
      @(negedge rclk);
    end
    if (!seen) begin
      pulse_errs++;
      $display("no miss_done pulse for miss address %h by %0t", addr, $time);
    end
  endtask

  task automatic drive_fill(input mb_id_t id);
    fill_vld = 1'b1;
    fill_id  = id;
    @(negedge rclk);
    fill_vld = 1'b0;
  endtask

  task automatic wait_retire(input mb_addr_t exp);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < PULSE_LIMIT && !seen; n++) begin
      if (retire_vld === 1'b1) begin
        seen = 1'b1;
        check_addr(retire_addr, exp);
      end
      @(negedge rclk);
    end
    if (!seen) begin
      pulse_errs++;
      $display("no retire_vld pulse for expected address %h by %0t", exp, $time);
    end
  endtask

  // duplicate first, then full, then allocate into lowest free entry
  task automatic model_miss(input mb_addr_t a, output mb_id_t id,
                            output miss_flags_t f);
    mb_wl_t dup_v;
    mb_wl_t idx_v;
    for (int j = 0; j < MB_ENTRIES; j++) begin
      dup_v[j] = ref_vld[j] &&
                 (ref_addr[j][MB_AW-1:MB_LINE_LO] == a[MB_AW-1:MB_LINE_LO]);
      idx_v[j] = ref_vld[j] &&
                 (ref_addr[j][MB_IDX_HI:MB_LINE_LO] == a[MB_IDX_HI:MB_LINE_LO]);
    end
    f  = '0;
    id = '0;
    if (dup_v != '0) begin
      f.dup = 1'b1;
      id    = lowest_set(dup_v);
    end else if (&ref_vld) begin
      f.full = 1'b1;
    end else begin
      id           = lowest_set(~ref_vld);
      f.conf       = |idx_v;
      ref_vld[id]  = 1'b1;
      ref_addr[id] = a;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    op_row_t     row;
    mb_id_t      id;
    mb_id_t      exp_id;
    miss_flags_t f;
    miss_flags_t exp_f;
    mb_addr_t    a;
    logic        seen;
    int          i;
    val_errs   = 0;
    pulse_errs = 0;
    rng        = 32'd1;
    ref_vld    = '0;
    miss_vld   = 1'b0;
    miss_addr  = '0;
    fill_vld   = 1'b0;
    fill_id    = '0;
    reset_dut();
    if (miss_rdy !== 1'b1) begin
      val_errs++;
      $display("Fail %0t: miss_rdy low after reset", $time);
    end

    // directed table
    i = 0;
    while (i < TBL_LEN) begin
      row = OP_TBL[i];
      if (!row.is_fill) begin
        run_miss(row.addr, id, f, seen);
        if (seen) begin
          check_miss(id, f, row.id, row.flags);
        end
        i++;
      end else if (row.pair && i + 1 < TBL_LEN) begin
        drive_fill(row.id);
        drive_fill(OP_TBL[i+1].id);
        wait_retire(row.addr);
        wait_retire(OP_TBL[i+1].addr);
        i += 2;
      end else begin
        drive_fill(row.id);
        wait_retire(row.addr);
        i++;
      end
    end

    // random section from a clean buffer
    reset_dut();
    ref_vld = '0;
    for (int n = 0; n < N_RAND; n++) begin
      rng = xorshift(rng);
      if (ref_vld != '0 && rng[2:0] < 3'd3) begin
        id          = pick_valid(ref_vld, rng[19:16]);
        a           = ref_addr[id];
        ref_vld[id] = 1'b0;
        drive_fill(id);
        wait_retire(a);
      end else begin
        // 4 tags by 16 sets keeps duplicates and conflicts frequent
        a = {20'hA5A5A, rng[9:8], 6'h00, rng[13:10], rng[7:0]};
        model_miss(a, exp_id, exp_f);
        run_miss(a, id, f, seen);
        if (seen) begin
          check_miss(id, f, exp_id, exp_f);
        end
      end
    end

    $display("errors: %0d wrong values, %0d missing pulses", val_errs, pulse_errs);
    if (val_errs == 0 && pulse_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: src/mb_top.sv
//////////////////////////////////////////////////////////////////////
// miss buffer top, allocator, address array and retire block
//////////////////////////////////////////////////////////////////////

module mb_top (
  input  logic             rclk,
  input  logic             rst_l,
  input  logic             miss_vld,
  input  mb_pkg::mb_addr_t miss_addr,
  output logic             miss_rdy,
  output logic             miss_done,
  output mb_pkg::mb_id_t   miss_id,
  output logic             miss_dup,
  output logic             miss_full,
  output logic             miss_conf,
  input  logic             fill_vld,
  input  mb_pkg::mb_id_t   fill_id,
  output logic             retire_vld,
  output mb_pkg::mb_addr_t retire_addr
);

  import mb_pkg::*;

  // allocator to array
  logic     srch_en;
  mb_key_t  srch_key;
  mb_wl_t   match;
  mb_wl_t   idx_match;
  logic     wr_en;
  mb_wr_t   wr;

  // retire to array and allocator
  logic     rd_en;
  mb_wl_t   rd_wl;
  mb_addr_t rd_addr;
  logic     free_en;
  mb_wl_t   free_wl;

  mb_alloc i_alloc (
    .rclk, .rst_l, .miss_vld, .miss_addr, .miss_rdy, .miss_done,
    .miss_id, .miss_dup, .miss_full, .miss_conf, .srch_en, .srch_key,
    .match, .idx_match, .wr_en, .wr, .free_en, .free_wl
  );

  mb_cam i_cam (
    .rclk, .rst_l, .wr_en, .wr, .rd_en, .rd_wl, .rd_addr,
    .srch_en, .srch_key, .match, .idx_match
  );

  mb_retire i_retire (
    .rclk, .rst_l, .fill_vld, .fill_id, .rd_en, .rd_wl, .free_en,
    .free_wl, .rd_addr, .retire_vld, .retire_addr
  );

endmodule

// File: src/mb_retire.sv
//////////////////////////////////////////////////////////////////////
// fill retire path, entry read and free, address return
//////////////////////////////////////////////////////////////////////

module mb_retire (
  input  logic             rclk,
  input  logic             rst_l,
  input  logic             fill_vld,
  input  mb_pkg::mb_id_t   fill_id,
  output logic             rd_en,
  output mb_pkg::mb_wl_t   rd_wl,
  output logic             free_en,
  output mb_pkg::mb_wl_t   free_wl,
  input  mb_pkg::mb_addr_t rd_addr,
  output logic             retire_vld,
  output mb_pkg::mb_addr_t retire_addr
);

  import mb_pkg::*;

  logic   fill_vld_q;
  mb_id_t fill_id_q;
  // one stage per array read cycle
  logic   rd_vld_d1;
  logic   rd_vld_d2;

  // fill input flops
  always_ff @(posedge rclk) begin
    fill_id_q <= fill_id;
  end

  always_ff @(posedge rclk) begin
    if (!rst_l) begin
      fill_vld_q <= 1'b0;
      rd_vld_d1  <= 1'b0;
      rd_vld_d2  <= 1'b0;
    end else begin
      fill_vld_q <= fill_vld;
      rd_vld_d1  <= fill_vld_q;
      rd_vld_d2  <= rd_vld_d1;
    end
  end

  // read and free the same entry in one cycle
  assign rd_en   = fill_vld_q;
  assign rd_wl   = mb_wl_t'(1) << fill_id_q;
  assign free_en = fill_vld_q;
  assign free_wl = rd_wl;

  // array read data lines up with the second stage
  assign retire_vld  = rd_vld_d2;
  assign retire_addr = rd_addr;

endmodule

// File: src/mb_alloc.sv
//////////////////////////////////////////////////////////////////////
// miss allocator, entry valid tracking, search sequencing and
// duplicate, full and index conflict classification
//////////////////////////////////////////////////////////////////////

module mb_alloc (
  input  logic             rclk,
  input  logic             rst_l,
  input  logic             miss_vld,
  input  mb_pkg::mb_addr_t miss_addr,
  output logic             miss_rdy,
  output logic             miss_done,
  output mb_pkg::mb_id_t   miss_id,
  output logic             miss_dup,
  output logic             miss_full,
  output logic             miss_conf,
  output logic             srch_en,
  output mb_pkg::mb_key_t  srch_key,
  input  mb_pkg::mb_wl_t   match,
  input  mb_pkg::mb_wl_t   idx_match,
  output logic             wr_en,
  output mb_pkg::mb_wr_t   wr,
  input  logic             free_en,
  input  mb_pkg::mb_wl_t   free_wl
);

  import mb_pkg::*;

  mb_alc_st_t state;
  mb_alc_st_t state_nxt;

  // one bit per entry holding a live miss
  mb_wl_t     valid;
  mb_addr_t   addr_q;
  logic       alloc_q;
  // second search cycle, array input and output flops take two edges
  logic       srch_2nd;

  // classification terms, used in ALC_WAIT
  mb_wl_t     hit_v;
  mb_wl_t     conf_v;
  logic       is_dup;
  logic       is_full;
  logic       do_alloc;
  mb_id_t     hit_id;
  mb_id_t     free_id;
  mb_wl_t     set_wl;
  mb_wl_t     clr_wl;

  // lowest set bit of a mask, zero when empty
  function automatic mb_id_t first_one(input mb_wl_t vec);
    mb_id_t idx;
    idx = '0;
    for (int i = MB_ENTRIES - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = mb_id_t'(i);
      end
    end
    return idx;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  // idle -> search for two cycles -> read match -> done pulse
  always_comb begin
    state_nxt = state;
    case (state)
      ALC_IDLE: if (miss_vld) state_nxt = ALC_SRCH;
      ALC_SRCH: if (srch_2nd) state_nxt = ALC_WAIT;
      ALC_WAIT: state_nxt = ALC_DONE;
      ALC_DONE: state_nxt = ALC_IDLE;
      default:  state_nxt = ALC_IDLE;
    endcase
  end

  assign miss_rdy  = (state == ALC_IDLE);
  assign srch_en   = (state == ALC_SRCH);
  assign srch_key  = addr_q[MB_AW-1:MB_LINE_LO];
  assign miss_done = (state == ALC_DONE);
  // write goes out with the done pulse
  assign wr_en     = miss_done && alloc_q;

  //////////////////////////////////////////////////////////////////////
  // classification
  //////////////////////////////////////////////////////////////////////

  // raw array hits mean nothing for invalid entries
  assign hit_v    = match & valid;
  assign conf_v   = idx_match & valid;
  assign is_dup   = |hit_v;
  assign is_full  = &valid;
  assign do_alloc = !is_dup && !is_full;
  assign hit_id   = first_one(hit_v);
  assign free_id  = first_one(~valid);

  // valid bit set on the edge that leaves ALC_WAIT
  assign set_wl = (state == ALC_WAIT && do_alloc) ? mb_wl_t'(1) << free_id : '0;
  assign clr_wl = free_en ? free_wl : '0;

  always_ff @(posedge rclk) begin
    if (!rst_l) begin
      state    <= ALC_IDLE;
      valid    <= '0;
      alloc_q  <= 1'b0;
      srch_2nd <= 1'b0;
    end else begin
      state    <= state_nxt;
      valid    <= (valid & ~clr_wl) | set_wl;
      srch_2nd <= (state == ALC_SRCH) && !srch_2nd;
      if (state == ALC_WAIT) begin
        alloc_q <= do_alloc;
      end
    end
  end

  // captured miss and outcome fields
  always_ff @(posedge rclk) begin
    if (miss_rdy && miss_vld) begin
      addr_q <= miss_addr;
    end
    if (state == ALC_WAIT) begin
      miss_dup  <= is_dup;
      miss_full <= !is_dup && is_full;
      miss_conf <= do_alloc && (|conf_v);
      // dup reports the hit, full reports zero
      miss_id   <= is_dup ? hit_id : (is_full ? '0 : free_id);
      wr.wl     <= mb_wl_t'(1) << free_id;
      wr.addr   <= addr_q;
    end
  end

endmodule

// File: src/mb_cam.sv
//////////////////////////////////////////////////////////////////////
// 16x40 miss address array with one-hot write and read ports and a
// registered line address search with index match
//////////////////////////////////////////////////////////////////////

module mb_cam (
  input  logic             rclk,
  input  logic             rst_l,
  input  logic             wr_en,
  input  mb_pkg::mb_wr_t   wr,
  input  logic             rd_en,
  input  mb_pkg::mb_wl_t   rd_wl,
  output mb_pkg::mb_addr_t rd_addr,
  input  logic             srch_en,
  input  mb_pkg::mb_key_t  srch_key,
  output mb_pkg::mb_wl_t   match,
  output mb_pkg::mb_wl_t   idx_match
);

  import mb_pkg::*;

  // storage, contents undefined until written
  mb_addr_t mem [MB_ENTRIES];

  // input flops
  logic     wr_en_q;
  mb_wr_t   wr_q;
  logic     rd_en_q;
  mb_wl_t   rd_wl_q;
  logic     srch_en_q;
  mb_key_t  srch_key_q;

  // decoded read data and raw compare results
  mb_addr_t rd_data;
  mb_wl_t   match_d;
  mb_wl_t   idx_match_d;

  //////////////////////////////////////////////////////////////////////
  // input registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge rclk) begin
    if (!rst_l) begin
      wr_en_q   <= 1'b0;
      rd_en_q   <= 1'b0;
      srch_en_q <= 1'b0;
    end else begin
      wr_en_q   <= wr_en;
      rd_en_q   <= rd_en;
      srch_en_q <= srch_en;
    end
  end

  // address and wordline flops
  always_ff @(posedge rclk) begin
    wr_q       <= wr;
    rd_wl_q    <= rd_wl;
    srch_key_q <= srch_key;
  end

  //////////////////////////////////////////////////////////////////////
  // write and read ports
  //////////////////////////////////////////////////////////////////////

  // only a clean one-hot wordline writes
  always_ff @(posedge rclk) begin
    for (int i = 0; i < MB_ENTRIES; i++) begin
      if (wr_en_q && $onehot(wr_q.wl) && wr_q.wl[i]) begin
        mem[i] <= wr_q.addr;
      end
    end
  end

  // empty or multi-hot read wordline senses all ones
  always_comb begin
    rd_data = '1;
    if ($onehot(rd_wl_q)) begin
      for (int i = 0; i < MB_ENTRIES; i++) begin
        if (rd_wl_q[i]) begin
          rd_data = mem[i];
        end
      end
    end
  end

  // sampled before a same-edge write lands, so old data comes back
  always_ff @(posedge rclk) begin
    if (rd_en_q) begin
      rd_addr <= rd_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // search
  //////////////////////////////////////////////////////////////////////

  // full line compare plus set index compare per entry
  always_comb begin
    for (int i = 0; i < MB_ENTRIES; i++) begin
      match_d[i]     = (mem[i][MB_AW-1:MB_LINE_LO] == srch_key_q);
      idx_match_d[i] = (mem[i][MB_IDX_HI:MB_LINE_LO] ==
                        srch_key_q[MB_IDX_HI-MB_LINE_LO:0]);
    end
  end

  // results stay zero when no search was issued
  always_ff @(posedge rclk) begin
    if (!rst_l) begin
      match     <= '0;
      idx_match <= '0;
    end else if (srch_en_q) begin
      match     <= match_d;
      idx_match <= idx_match_d;
    end else begin
      match     <= '0;
      idx_match <= '0;
    end
  end

endmodule

// File: src/mb_pkg.sv
//////////////////////////////////////////////////////////////////////
// miss buffer sizes, address and wordline types, array write port
// struct and allocator state encoding
//////////////////////////////////////////////////////////////////////

package mb_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  // number of outstanding misses held in the array
  localparam int MB_ENTRIES = 16;
  // physical address width
  localparam int MB_AW      = 40;
  // lowest bit of the line address, 256 byte lines
  localparam int MB_LINE_LO = 8;
  // top bit of the cache set index
  localparam int MB_IDX_HI  = 17;

  // derived widths
  localparam int MB_IDW     = $clog2(MB_ENTRIES);
  localparam int MB_KW      = MB_AW - MB_LINE_LO;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  // full physical miss address
  typedef logic [MB_AW-1:0]      mb_addr_t;
  // one-hot wordline or entry mask
  typedef logic [MB_ENTRIES-1:0] mb_wl_t;
  // binary entry number
  typedef logic [MB_IDW-1:0]     mb_id_t;
  // line address, addr[39:8]
  typedef logic [MB_KW-1:0]      mb_key_t;

  // array write port
  typedef struct packed {
    mb_wl_t   wl;
    mb_addr_t addr;
  } mb_wr_t;

  // allocator FSM
  typedef enum logic [1:0] {
    ALC_IDLE,
    ALC_SRCH,
    ALC_WAIT,
    ALC_DONE
  } mb_alc_st_t;

endpackage
